//--- compile.f
+incdir+dv
design/pmu_pkg.sv
design/llc_event_sampler.sv
design/event_fifo.sv
design/pmu_counter_bank.sv
design/llc_pmu_top.sv
dv/llc_pmu_tb.sv

//--- design/event_fifo.sv
/*
  Circular buffer of event records.
  FIFO_DEPTH must be a power of two and at least 2.
  A push while full is ignored. Push and pop may happen in the same cycle.
*/
`timescale 1ns/1ns
`default_nettype none

module event_fifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                push_i,
  input  pmu_pkg::event_rec_t rec_i,
  input  logic                pop_i,
  output pmu_pkg::event_rec_t rec_o,
  output logic                full_o,
  output logic                empty_o
);

  localparam int unsigned PtrWidth = $clog2(FIFO_DEPTH);

  pmu_pkg::event_rec_t mem_q [FIFO_DEPTH];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == FIFO_DEPTH[PtrWidth:0]);
  assign empty_o = (count_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  // Head of the queue, stale while empty
  assign rec_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- design/llc_event_sampler.sv
/*
  Samples the four LLC event strobes once per cycle.
  A nonzero strobe vector becomes a record that is pushed one cycle later.
  While the FIFO is full, the held record waits and new records are dropped.
*/
`timescale 1ns/1ns
`default_nettype none

module llc_event_sampler (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [3:0]            llc_event_i,
  input  logic                  full_i,
  output logic                  push_o,
  output pmu_pkg::event_rec_t   rec_o,
  output logic                  drop_o
);

  logic                push_q;
  pmu_pkg::event_rec_t rec_q;
  logic                blocked;
  logic                new_rec;

  // Held record cannot enter the FIFO this cycle
  assign blocked = push_q && full_i;

  // Strobe bits already sit in llc_event_e order
  assign new_rec = |llc_event_i;

  // Valid flag of the held record
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      push_q <= 1'b0;
    end else if (!blocked) begin
      push_q <= new_rec;
    end
  end

  // Record payload, kept while blocked
  always_ff @(posedge clk_i) begin
    if (!blocked) begin
      rec_q.mask <= llc_event_i;
    end
  end

  assign push_o = push_q;
  assign rec_o  = rec_q;

  // A record is lost when a new one arrives behind a blocked one
  assign drop_o = blocked && new_rec;

endmodule

`default_nettype wire

//--- design/llc_pmu_top.sv
/*
  LLC performance monitor: sampler, event FIFO and counter bank.
  FIFO_DEPTH must be a power of two, at least 2. CNT_WIDTH is at most 32.
  With an empty FIFO and no freeze, a strobe reaches the counters in 3 cycles.
*/
`timescale 1ns/1ns
`default_nettype none

module llc_pmu_top #(
  parameter int unsigned FIFO_DEPTH = 8,
  parameter int unsigned CNT_WIDTH  = 32
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic [3:0]        llc_event_i,
  input  pmu_pkg::reg_req_t reg_req_i,
  output pmu_pkg::reg_rsp_t reg_rsp_o,
  output logic              irq_o
);

  // Sampler to FIFO
  logic                push;
  pmu_pkg::event_rec_t sampled_rec;
  logic                fifo_full;

  // FIFO to counter bank
  logic                pop;
  pmu_pkg::event_rec_t head_rec;
  logic                fifo_empty;

  // Lost records
  logic                drop;

  llc_event_sampler i_sampler (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .llc_event_i ( llc_event_i ),
    .full_i      ( fifo_full   ),
    .push_o      ( push        ),
    .rec_o       ( sampled_rec ),
    .drop_o      ( drop        )
  );

  event_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_event_fifo (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .push_i   ( push        ),
    .rec_i    ( sampled_rec ),
    .pop_i    ( pop         ),
    .rec_o    ( head_rec    ),
    .full_o   ( fifo_full   ),
    .empty_o  ( fifo_empty  )
  );

  // Sampler push doubles as its busy flag for STATUS.drained
  pmu_counter_bank #(
    .CNT_WIDTH ( CNT_WIDTH )
  ) i_counter_bank (
    .clk_i          ( clk_i      ),
    .arst_n_i       ( arst_n_i   ),
    .rec_i          ( head_rec   ),
    .empty_i        ( fifo_empty ),
    .pop_o          ( pop        ),
    .drop_i         ( drop       ),
    .sampler_busy_i ( push       ),
    .reg_req_i      ( reg_req_i  ),
    .reg_rsp_o      ( reg_rsp_o  ),
    .irq_o          ( irq_o      )
  );

endmodule

`default_nettype wire

//--- design/pmu_counter_bank.sv
/*
  Event counters with CTRL, STATUS and THRESH registers.
  CNT_WIDTH is at most 32. Counters wrap, and reads are zero-extended.
  Register responses come exactly one cycle after the request.
  A record popped in the same cycle as a CTRL.clear write is not counted.
*/
`timescale 1ns/1ns
`default_nettype none

module pmu_counter_bank #(
  parameter int unsigned CNT_WIDTH = 32
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  pmu_pkg::event_rec_t rec_i,
  input  logic                empty_i,
  output logic                pop_o,
  input  logic                drop_i,
  input  logic                sampler_busy_i,
  input  pmu_pkg::reg_req_t   reg_req_i,
  output pmu_pkg::reg_rsp_t   reg_rsp_o,
  output logic                irq_o
);

  localparam int unsigned NumEv = pmu_pkg::NumEvents;

  // Register bit positions
  localparam int unsigned CtrlFreezeBit = 4;
  localparam int unsigned CtrlClearBit  = 5;
  localparam int unsigned StatOvfBit    = 8;
  localparam int unsigned StatDrainBit  = 9;

  logic [NumEv-1:0]                en_q;
  logic                            freeze_q;
  logic [CNT_WIDTH-1:0]            thresh_q;
  logic [NumEv-1:0]                pend_q;
  logic [NumEv-1:0]                pend_d;
  logic [NumEv-1:0]                pend_set;
  logic                            ovf_q;
  logic [NumEv-1:0][CNT_WIDTH-1:0] cnt_q;
  logic [NumEv-1:0][CNT_WIDTH-1:0] cnt_d;

  pmu_pkg::reg_addr_e              req_addr;
  pmu_pkg::llc_event_e             cnt_sel;
  logic                            wr_en;
  logic                            wr_ctrl;
  logic                            wr_status;
  logic                            wr_thresh;
  logic                            clear;
  logic                            drained;
  logic [pmu_pkg::RegDataWidth-1:0] rdata;
  logic                            rd_err;

  logic                            rsp_valid_q;
  logic                            rsp_err_q;
  logic [pmu_pkg::RegDataWidth-1:0] rsp_rdata_q;

  // Request decode
  assign req_addr  = pmu_pkg::reg_addr_e'(reg_req_i.addr);
  assign cnt_sel   = pmu_pkg::llc_event_e'(reg_req_i.addr[1:0]);
  assign wr_en     = reg_req_i.valid && (reg_req_i.op == pmu_pkg::REG_WRITE);
  assign wr_ctrl   = wr_en && (req_addr == pmu_pkg::CTRL);
  assign wr_status = wr_en && (req_addr == pmu_pkg::STATUS);
  assign wr_thresh = wr_en && (req_addr == pmu_pkg::THRESH);
  assign clear     = wr_ctrl && reg_req_i.wdata[CtrlClearBit];

  // Drain the FIFO unless software froze the bank
  assign pop_o = !empty_i && !freeze_q;

  // Nothing left in the sampler or in the FIFO
  assign drained = !sampler_busy_i && empty_i;

  // Counting and threshold detection
  always_comb begin
    cnt_d    = cnt_q;
    pend_set = '0;
    for (int i = 0; i < NumEv; i++) begin
      if (pop_o && rec_i.mask[i] && en_q[i]) begin
        cnt_d[i]    = cnt_q[i] + 1'b1;
        pend_set[i] = (thresh_q != '0) && (cnt_d[i] == thresh_q);
      end
    end
    if (clear) begin
      cnt_d = '0;
    end
  end

  // Write-1-to-clear pending bits
  // A new hit in the same cycle wins
  always_comb begin
    pend_d = pend_q;
    if (wr_status) begin
      pend_d = pend_d & ~reg_req_i.wdata[NumEv-1:0];
    end
    pend_d = pend_d | pend_set;
    if (clear) begin
      pend_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q     <= '0;
      freeze_q <= 1'b0;
      thresh_q <= '0;
      pend_q   <= '0;
      ovf_q    <= 1'b0;
      cnt_q    <= '0;
    end else begin
      if (wr_ctrl) begin
        en_q     <= reg_req_i.wdata[NumEv-1:0];
        freeze_q <= reg_req_i.wdata[CtrlFreezeBit];
      end
      if (wr_thresh) begin
        thresh_q <= reg_req_i.wdata[CNT_WIDTH-1:0];
      end
      // Sticky overflow that a drop in the clearing cycle keeps set
      if (drop_i) begin
        ovf_q <= 1'b1;
      end else if (wr_status && reg_req_i.wdata[StatOvfBit]) begin
        ovf_q <= 1'b0;
      end
      pend_q <= pend_d;
      cnt_q  <= cnt_d;
    end
  end

  // Read mux of the values before this edge
  always_comb begin
    rdata  = '0;
    rd_err = 1'b0;
    case (req_addr)
      pmu_pkg::CTRL: begin
        rdata[NumEv-1:0]     = en_q;
        rdata[CtrlFreezeBit] = freeze_q;
      end
      pmu_pkg::STATUS: begin
        rdata[NumEv-1:0]    = pend_q;
        rdata[StatOvfBit]   = ovf_q;
        rdata[StatDrainBit] = drained;
      end
      pmu_pkg::THRESH: begin
        rdata[CNT_WIDTH-1:0] = thresh_q;
      end
      pmu_pkg::CNT0, pmu_pkg::CNT1, pmu_pkg::CNT2, pmu_pkg::CNT3: begin
        rdata[CNT_WIDTH-1:0] = cnt_q[cnt_sel];
      end
      default: begin
        rd_err = 1'b1;
      end
    endcase
  end

  // Response strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= reg_req_i.valid;
    end
  end

  // Response payload where writes return zero data
  always_ff @(posedge clk_i) begin
    if (reg_req_i.valid) begin
      rsp_err_q   <= rd_err;
      rsp_rdata_q <= wr_en ? '0 : rdata;
    end
  end

  assign reg_rsp_o.valid = rsp_valid_q;
  assign reg_rsp_o.err   = rsp_err_q;
  assign reg_rsp_o.rdata = rsp_rdata_q;

  assign irq_o = |pend_q;

endmodule

`default_nettype wire

//--- design/pmu_pkg.sv
/*
  Shared types of the LLC performance monitor.
  The register port uses a 3-bit word address, and address 3 is unmapped.
  Record mask bits and strobe bits follow the order of llc_event_e.
*/
`default_nettype none

package pmu_pkg;

  // Number of cache event kinds reported by the LLC
  localparam int unsigned NumEvents = 4;

  // Register port data width
  localparam int unsigned RegDataWidth = 32;

  // Bit position of each event kind
  typedef enum logic [1:0] {
    EV_READ_HIT   = 2'd0,
    EV_READ_MISS  = 2'd1,
    EV_WRITE_HIT  = 2'd2,
    EV_WRITE_MISS = 2'd3
  } llc_event_e;

  // One sampled cycle, one bit per event kind
  typedef struct packed {
    logic [NumEvents-1:0] mask;
  } event_rec_t;

  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

  // Word addresses of the register map
  typedef enum logic [2:0] {
    CTRL   = 3'd0,
    STATUS = 3'd1,
    THRESH = 3'd2,
    CNT0   = 3'd4,
    CNT1   = 3'd5,
    CNT2   = 3'd6,
    CNT3   = 3'd7
  } reg_addr_e;

  typedef struct packed {
    logic                    valid;
    reg_op_e                 op;
    logic [2:0]              addr;
    logic [RegDataWidth-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                    valid;
    logic                    err;
    logic [RegDataWidth-1:0] rdata;
  } reg_rsp_t;

endpackage

`default_nettype wire

//--- dv/llc_pmu_tb_tasks.svh
/*
  Register access, strobe drivers and wait loops for the PMU testbench.
  Included inside llc_pmu_tb and uses its signals, model and error tasks.
  One request at a time. Each wait loop stops the run on its own timeout.
*/
`ifndef LLC_PMU_TB_TASKS_SVH
`define LLC_PMU_TB_TASKS_SVH

  // Numerical Recipes LCG constants
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // One request, then wait for its response pulse
  task automatic issue_request(input pmu_pkg::reg_op_e op, input logic [2:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
    int unsigned waited;
    waited = 0;
    @(posedge clk);
    reg_req <= '{valid: 1'b1, op: op, addr: addr, wdata: wdata};
    @(posedge clk);
    reg_req.valid <= 1'b0;
    @(negedge clk);
    while (!reg_rsp.valid) begin
      waited++;
      if (waited > RspTimeout) begin
        fail_text("no register response before the timeout");
      end
      @(negedge clk);
    end
    rdata = reg_rsp.rdata;
    err   = reg_rsp.err;
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    issue_request(pmu_pkg::REG_WRITE, addr, wdata, rdata, err);
    assert (err == 1'b0) else fail_value("write err", 32'h0, 32'(err));
  endtask

  task automatic check_reg(input string what, input logic [2:0] addr,
                           input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    issue_request(pmu_pkg::REG_READ, addr, 32'h0, rdata, err);
    assert (err == 1'b0) else fail_value({what, " err"}, 32'h0, 32'(err));
    assert (rdata == exp) else fail_value(what, exp, rdata);
  endtask

  // Poll STATUS.drained until the sampler and FIFO are empty
  task automatic wait_drained();
    logic [31:0] rdata;
    logic        err;
    int unsigned polls;
    polls = 0;
    issue_request(pmu_pkg::REG_READ, pmu_pkg::STATUS, 32'h0, rdata, err);
    while (!rdata[9]) begin
      polls++;
      if (polls > DrainTimeout) begin
        fail_text("STATUS.drained did not rise before the timeout");
      end
      issue_request(pmu_pkg::REG_READ, pmu_pkg::STATUS, 32'h0, rdata, err);
    end
  endtask

  // Random strobe vectors, optionally forced nonzero
  task automatic drive_random(input int unsigned cycles, input logic nonzero);
    logic [3:0] mask;
    for (int unsigned n = 0; n < cycles; n++) begin
      rng_state = lcg_next(rng_state);
      mask = rng_state[27:24];
      if (nonzero && mask == 4'b0) begin
        mask = 4'b1000;
      end
      @(posedge clk);
      llc_event <= mask;
    end
    @(posedge clk);
    llc_event <= 4'b0;
  endtask

  task automatic drive_fixed(input logic [3:0] mask, input int unsigned cycles);
    for (int unsigned n = 0; n < cycles; n++) begin
      @(posedge clk);
      llc_event <= mask;
    end
    @(posedge clk);
    llc_event <= 4'b0;
  endtask

`endif

//--- dv/llc_pmu_tb.sv
/*
  Testbench for the LLC performance monitor, stops at the first error.
  Expected values come from a model of the enable mask, freeze,
  the FIFO drop rule and the threshold rule, updated as the DUT samples.
*/
`timescale 1ns/1ns
`default_nettype none

module llc_pmu_tb;

  localparam int unsigned FIFO_DEPTH   = 8;
  localparam int unsigned NumEv        = pmu_pkg::NumEvents;
  localparam int unsigned RspTimeout   = 4;
  localparam int unsigned DrainTimeout = 100;

  logic              clk;
  logic              arst_n;
  logic [3:0]        llc_event;
  pmu_pkg::reg_req_t reg_req;
  pmu_pkg::reg_rsp_t reg_rsp;
  logic              irq;

  // Reference model state
  logic [31:0] model_cnt [NumEv];
  logic [3:0]  model_en;
  logic        model_freeze;
  logic [31:0] model_thresh;
  logic [3:0]  model_pend;
  logic        model_ovf;
  logic [3:0]  backlog [$];

  logic [31:0] rng_state;
  string       test_name;

  llc_pmu_top #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) UUT (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .llc_event_i ( llc_event ),
    .reg_req_i   ( reg_req   ),
    .reg_rsp_o   ( reg_rsp   ),
    .irq_o       ( irq       )
  );

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic fail_value(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
    $display("[ERROR] %s, %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
    stop_run();
  endtask

  task automatic fail_text(input string what);
    $display("[ERROR] %s: %s", test_name, what);
    stop_run();
  endtask

  `include "llc_pmu_tb_tasks.svh"

  // One record reaching the counters
  function automatic void count_record(input logic [3:0] mask);
    for (int i = 0; i < NumEv; i++) begin
      if (mask[i] && model_en[i]) begin
        model_cnt[i] = model_cnt[i] + 32'd1;
        if (model_thresh != 32'd0 && model_cnt[i] == model_thresh) begin
          model_pend[i] = 1'b1;
        end
      end
    end
  endfunction

  function automatic void model_write(input logic [2:0] addr, input logic [31:0] wdata);
    case (addr)
      pmu_pkg::CTRL: begin
        model_en = wdata[3:0];
        if (wdata[5]) begin
          model_cnt  = '{default: 32'd0};
          model_pend = 4'b0;
        end
        // Releasing freeze lets the held records through
        if (model_freeze && !wdata[4]) begin
          foreach (backlog[i]) begin
            count_record(backlog[i]);
          end
          backlog.delete();
        end
        model_freeze = wdata[4];
      end
      pmu_pkg::STATUS: begin
        model_pend = model_pend & ~wdata[3:0];
        if (wdata[8]) begin
          model_ovf = 1'b0;
        end
      end
      pmu_pkg::THRESH: model_thresh = wdata;
      default: ;
    endcase
  endfunction

  // Expected STATUS once the pipeline is drained
  function automatic logic [31:0] expected_status();
    return {22'b0, 1'b1, model_ovf, 4'b0, model_pend};
  endfunction

  // Model follows the DUT edge by edge
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      model_cnt    = '{default: 32'd0};
      model_en     = 4'b0;
      model_freeze = 1'b0;
      model_thresh = 32'd0;
      model_pend   = 4'b0;
      model_ovf    = 1'b0;
      backlog.delete();
    end else begin
      if (reg_req.valid && reg_req.op == pmu_pkg::REG_WRITE) begin
        model_write(reg_req.addr, reg_req.wdata);
      end
      if (llc_event != 4'b0) begin
        // FIFO_DEPTH in the FIFO plus one in the sampler
        if (!model_freeze) begin
          count_record(llc_event);
        end else if (backlog.size() < FIFO_DEPTH + 1) begin
          backlog.push_back(llc_event);
        end else begin
          model_ovf = 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    reg_rsp.valid == $past(reg_req.valid))
  else fail_text("response pulse was not exactly one cycle after its request");

  assert property (@(posedge clk) disable iff (!arst_n)
    UUT.i_counter_bank.drained |-> (irq == (|model_pend)))
  else fail_value("irq_o while drained", $sampled(|model_pend), $sampled(irq));

  task automatic check_counters();
    for (int i = 0; i < NumEv; i++) begin
      check_reg($sformatf("CNT%0d", i), 3'(4 + i), model_cnt[i]);
    end
  endtask

  task automatic check_irq(input logic exp);
    @(negedge clk);
    assert (irq == exp) else fail_value("irq_o", 32'(exp), 32'(irq));
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    logic [31:0] rdata;
    logic        err;
    rng_state = 32'h66a7a10f;
    arst_n    = 1'b0;
    llc_event = 4'b0;
    reg_req   = '0;
    test_name = "reset";
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    check_reg("CTRL", pmu_pkg::CTRL, 32'h0);
    check_reg("STATUS", pmu_pkg::STATUS, expected_status());
    check_reg("THRESH", pmu_pkg::THRESH, 32'h0);
    check_counters();
    check_irq(1'b0);
    issue_request(pmu_pkg::REG_READ, 3'd3, 32'h0, rdata, err);
    assert (err == 1'b1) else fail_value("unmapped err", 32'h1, 32'(err));
    assert (rdata == 32'h0) else fail_value("unmapped rdata", 32'h0, rdata);

    test_name = "counting";
    write_reg(pmu_pkg::CTRL, 32'h0000_000f);
    drive_random(200, 1'b0);
    wait_drained();
    check_counters();

    test_name = "enable_mask";
    write_reg(pmu_pkg::CTRL, 32'h0000_0020);
    // Read miss and write hit only
    write_reg(pmu_pkg::CTRL, 32'h0000_0006);
    drive_random(200, 1'b0);
    wait_drained();
    check_counters();

    test_name = "freeze_overflow";
    write_reg(pmu_pkg::CTRL, 32'h0000_003f);
    drive_random(20, 1'b1);
    write_reg(pmu_pkg::CTRL, 32'h0000_000f);
    wait_drained();
    check_counters();
    check_reg("STATUS overflow set", pmu_pkg::STATUS, expected_status() | 32'h100);
    write_reg(pmu_pkg::STATUS, 32'h0000_0100);
    check_reg("STATUS overflow cleared", pmu_pkg::STATUS, 32'h0000_0200);

    test_name = "threshold";
    write_reg(pmu_pkg::CTRL, 32'h0000_002f);
    write_reg(pmu_pkg::THRESH, 32'd5);
    drive_fixed(4'b0001, 4);
    wait_drained();
    check_irq(1'b0);
    check_reg("STATUS below threshold", pmu_pkg::STATUS, 32'h0000_0200);
    drive_fixed(4'b0001, 1);
    wait_drained();
    check_reg("STATUS at threshold", pmu_pkg::STATUS, 32'h0000_0201);
    check_irq(1'b1);
    write_reg(pmu_pkg::STATUS, 32'h0000_0001);
    check_irq(1'b0);
    check_counters();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
